// ==== l2_axi_defs.svh ====
// ====================================================================
// l2 line transfer engine, line geometry and bus widths
// ====================================================================
`ifndef L2_AXI_DEFS_SVH
`define L2_AXI_DEFS_SVH

// words per cache line, also the AXI burst length
`define L2_LINE_WORDS 4

// byte address width on the AXI side
`define L2_ADDR_W 32

// data word width, one word per beat
`define L2_DATA_W 32

`endif

// ==== l2_axi_pkg.sv ====
// ====================================================================
// l2 line transfer engine, shared types and channel state encodings
// ====================================================================
`include "l2_axi_defs.svh"

package l2_axi_pkg;

    typedef logic [`L2_ADDR_W-1:0] addr_t;   // byte address
    typedef logic [`L2_DATA_W-1:0] word_t;   // one data beat

    // beat index plus one bit so a full fifo count fits
    typedef logic [$clog2(`L2_LINE_WORDS):0] beat_t;

    typedef logic [1:0] resp_t;              // AXI xRESP
    localparam resp_t RESP_OKAY = 2'b00;     // anything else is an error

    // read channel flow
    typedef enum logic [1:0] {RD_IDLE, RD_AR, RD_R} rd_state_e;

    // write channel flow
    typedef enum logic [1:0] {WR_IDLE, WR_AW, WR_W, WR_B} wr_state_e;

endpackage

// ==== l2_rd_if.sv ====
// ====================================================================
// read request path, line controller to AXI channel engine
// ====================================================================
`timescale 1ns/1ns

interface l2_rd_if
    import l2_axi_pkg::*;
();
    logic  req;       // level, held until last
    addr_t addr;      // line address of the fill
    logic  addr_ok;   // AR accepted, data phase running
    logic  beat;      // one accepted R beat
    word_t data;
    logic  last;      // final beat of the burst
    logic  err;       // accumulated rresp error, valid with last

    modport ctrl (output req, addr,
                  input  addr_ok, beat, data, last, err);

    modport eng  (input  req, addr,
                  output addr_ok, beat, data, last, err);

endinterface

// ==== l2_wr_if.sv ====
// ====================================================================
// write request path and victim fifo pop side toward the W channel
// ====================================================================
`timescale 1ns/1ns

interface l2_wr_if
    import l2_axi_pkg::*;
();
    logic  req;        // level, held until done
    addr_t addr;       // victim line address
    logic  wd_valid;   // fifo not empty
    word_t wd_data;    // fifo head word
    logic  wd_pop;     // W handshake, fifo drops its head
    logic  done;       // one cycle, B accepted
    logic  err;        // bresp not OKAY, valid with done

    // request side
    modport ctrl (output req, addr,
                  input  done, err);

    // victim word fifo
    modport fifo (output wd_valid, wd_data,
                  input  wd_pop);

    // AXI channel engine
    modport eng  (input  req, addr, wd_valid, wd_data,
                  output wd_pop, done, err);

endinterface

// ==== l2_line_ctrl.sv ====
// ====================================================================
// line request controller, holds fill and evict requests until the
// engine reports completion
// ====================================================================
`timescale 1ns/1ns

module l2_line_ctrl
    import l2_axi_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  fill_start,
    input  logic  evict_start,
    input  addr_t fill_addr,
    input  addr_t evict_addr,
    output logic  fill_busy,
    output logic  fill_done,
    output logic  fill_err,
    output logic  evict_busy,
    output logic  evict_done,
    output logic  evict_err,
    l2_rd_if.ctrl rd,
    l2_wr_if.ctrl wr
);

    logic  fill_req;
    logic  evict_req;
    addr_t fill_addr_q;
    addr_t evict_addr_q;

    // fill completes on the last R beat of the data phase
    assign fill_done  = rd.last && rd.addr_ok;
    assign fill_err   = fill_done && rd.err;
    assign evict_done = wr.done;
    assign evict_err  = wr.done && wr.err;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fill_req <= 1'b0;
        end else if (fill_done) begin
            fill_req <= 1'b0;
        end else if (fill_start) begin
            fill_req <= 1'b1;   // no effect while already busy
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            evict_req <= 1'b0;
        end else if (evict_done) begin
            evict_req <= 1'b0;
        end else if (evict_start) begin
            evict_req <= 1'b1;
        end
    end

    // address only taken by an accepted start
    always_ff @(posedge clk) begin
        if (fill_start && !fill_req) fill_addr_q <= fill_addr;
        if (evict_start && !evict_req) evict_addr_q <= evict_addr;
    end

    assign fill_busy  = fill_req;
    assign evict_busy = evict_req;
    assign rd.req     = fill_req;
    assign rd.addr    = fill_addr_q;
    assign wr.req     = evict_req;
    assign wr.addr    = evict_addr_q;

endmodule

// ==== l2_wb_buffer.sv ====
// ====================================================================
// victim word fifo, cache side word strobes in, AXI W beats out
// ====================================================================
`timescale 1ns/1ns
`include "l2_axi_defs.svh"

module l2_wb_buffer
    import l2_axi_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  evict_wvalid,
    input  word_t evict_wdata,
    output logic  evict_wready,
    l2_wr_if.fifo wr
);

    localparam int DEPTH = `L2_LINE_WORDS;
    localparam int PW    = $clog2(DEPTH);
    localparam logic [PW-1:0] LAST_PTR = PW'(DEPTH - 1);

    word_t         mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    beat_t         count;
    logic          push;
    logic          pop;

    assign evict_wready = (count != beat_t'(DEPTH));   // low when full
    assign push         = evict_wvalid && evict_wready;
    assign pop          = wr.wd_pop && (count != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= evict_wdata;
    end

    assign wr.wd_valid = (count != '0);
    assign wr.wd_data  = mem[rd_ptr];   // head word

endmodule

// ==== l2_axi_interface.sv ====
// ====================================================================
// AXI channel engine, parallel AR/R and AW/W/B flows for line bursts
// ====================================================================
`timescale 1ns/1ns
`include "l2_axi_defs.svh"

module l2_axi_interface
    import l2_axi_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    l2_rd_if.eng  rd,
    l2_wr_if.eng  wr,
    output addr_t araddr,
    output logic  arvalid,
    input  logic  arready,
    input  word_t rdata,
    input  resp_t rresp,
    input  logic  rvalid,
    input  logic  rlast,
    output logic  rready,
    output addr_t awaddr,
    output logic  awvalid,
    input  logic  awready,
    output word_t wdata,
    output logic  wvalid,
    output logic  wlast,
    input  logic  wready,
    input  resp_t bresp,
    input  logic  bvalid,
    output logic  bready
);

    localparam beat_t LAST_BEAT = beat_t'(`L2_LINE_WORDS - 1);

    rd_state_e rd_state, rd_next;
    wr_state_e wr_state, wr_next;
    logic      err_acc;
    beat_t     beat_cnt;
    logic      w_fire;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_state <= RD_IDLE;
            wr_state <= WR_IDLE;
        end else begin
            rd_state <= rd_next;
            wr_state <= wr_next;
        end
    end

    // read flow
    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_IDLE: if (rd.req) rd_next = RD_AR;
            RD_AR:   if (arready) rd_next = RD_R;
            RD_R:    if (rvalid && rlast) rd_next = RD_IDLE;
            default: rd_next = RD_IDLE;
        endcase
    end

    assign araddr     = rd.addr;
    assign arvalid    = (rd_state == RD_AR);
    assign rready     = (rd_state == RD_R);
    assign rd.addr_ok = (rd_state == RD_R);
    assign rd.beat    = rready && rvalid;
    assign rd.data    = rdata;
    assign rd.last    = rd.beat && rlast;
    assign rd.err     = err_acc || (rd.beat && rresp != RESP_OKAY);   // current beat included

    // error sticky over the burst, cleared per request
    always_ff @(posedge clk) begin
        if (!rstn) begin
            err_acc <= 1'b0;
        end else if (rd_state == RD_AR) begin
            err_acc <= 1'b0;
        end else if (rd.beat && rresp != RESP_OKAY) begin
            err_acc <= 1'b1;
        end
    end

    // write flow
    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            WR_IDLE: if (wr.req) wr_next = WR_AW;
            WR_AW:   if (awready) wr_next = WR_W;
            WR_W:    if (w_fire && wlast) wr_next = WR_B;
            WR_B:    if (bvalid) wr_next = WR_IDLE;
            default: wr_next = WR_IDLE;
        endcase
    end

    assign awaddr  = wr.addr;
    assign awvalid = (wr_state == WR_AW);
    assign wvalid  = (wr_state == WR_W) && wr.wd_valid;   // empty fifo stalls W
    assign wdata   = wr.wd_data;
    assign wlast   = (wr_state == WR_W) && (beat_cnt == LAST_BEAT);
    assign w_fire  = wvalid && wready;
    assign bready  = (wr_state == WR_B);

    assign wr.wd_pop = w_fire;
    assign wr.done   = bready && bvalid;
    assign wr.err    = (bresp != RESP_OKAY);

    // W beats accepted so far in this burst
    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (wr_state != WR_W) begin
            beat_cnt <= '0;
        end else if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

endmodule

// ==== l2_axi_top.sv ====
// ====================================================================
// l2 line transfer engine top, cache side and AXI master ports
// ====================================================================
`timescale 1ns/1ns

module l2_axi_top
    import l2_axi_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    // fill requests
    input  logic  fill_start,
    input  addr_t fill_addr,
    output logic  fill_valid,
    output word_t fill_data,
    output logic  fill_done,
    output logic  fill_err,
    output logic  fill_busy,
    // evict requests and victim words
    input  logic  evict_start,
    input  addr_t evict_addr,
    input  logic  evict_wvalid,
    input  word_t evict_wdata,
    output logic  evict_wready,
    output logic  evict_done,
    output logic  evict_err,
    output logic  evict_busy,
    // AXI master
    output addr_t araddr,
    output logic  arvalid,
    input  logic  arready,
    input  word_t rdata,
    input  resp_t rresp,
    input  logic  rvalid,
    output logic  rready,
    input  logic  rlast,
    output addr_t awaddr,
    output logic  awvalid,
    input  logic  awready,
    output word_t wdata,
    output logic  wvalid,
    input  logic  wready,
    output logic  wlast,
    input  resp_t bresp,
    input  logic  bvalid,
    output logic  bready
);

    l2_rd_if rd_bus ();
    l2_wr_if wr_bus ();

    // fill beats go straight out to the cache
    assign fill_valid = rd_bus.beat;
    assign fill_data  = rd_bus.data;

    l2_line_ctrl u_line_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .fill_start  (fill_start),
        .evict_start (evict_start),
        .fill_addr   (fill_addr),
        .evict_addr  (evict_addr),
        .fill_busy   (fill_busy),
        .fill_done   (fill_done),
        .fill_err    (fill_err),
        .evict_busy  (evict_busy),
        .evict_done  (evict_done),
        .evict_err   (evict_err),
        .rd          (rd_bus.ctrl),
        .wr          (wr_bus.ctrl)
    );

    l2_wb_buffer u_wb_buffer (
        .clk          (clk),
        .rstn         (rstn),
        .evict_wvalid (evict_wvalid),
        .evict_wdata  (evict_wdata),
        .evict_wready (evict_wready),
        .wr           (wr_bus.fifo)
    );

    l2_axi_interface u_axi_interface (
        .clk     (clk),
        .rstn    (rstn),
        .rd      (rd_bus.eng),
        .wr      (wr_bus.eng),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rlast   (rlast),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wlast   (wlast),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

// ==== tb_clkgen.sv ====
// ====================================================================
// testbench clock (10 ns period) and synchronous reset generator
// ====================================================================
`timescale 1ns/1ns

module tb_clkgen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held low for 8 rising edges
    initial begin
        rstn = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

// ==== tb_l2_axi.sv ====
// ====================================================================
// testbench for the l2 line transfer engine, file driven AXI slave
// ====================================================================
`timescale 1ns/1ns
`include "l2_axi_defs.svh"

module tb_l2_axi
    import l2_axi_pkg::*;
();
    localparam int NW      = `L2_LINE_WORDS;
    localparam int MAX_OPS = 64;

    logic  clk, rstn;
    logic  fill_start, fill_valid, fill_done, fill_err, fill_busy;
    logic  evict_start, evict_wvalid, evict_wready, evict_done, evict_err, evict_busy;
    addr_t fill_addr, evict_addr, araddr, awaddr;
    word_t fill_data, evict_wdata, rdata, wdata;
    logic  arvalid, arready, rvalid, rready, rlast;
    logic  awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    resp_t rresp, bresp;

    // operations read from the stimulus file
    logic [7:0] op_code [MAX_OPS];
    addr_t      op_addr [MAX_OPS];
    word_t      op_words [MAX_OPS][NW];
    resp_t      op_resp [MAX_OPS];
    int         op_ebeat [MAX_OPS];

    int          n_ops = 0;
    int          limit_cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          test_errs = 0;
    int          fill_beats = 0;
    int          aw_count = 0;
    logic        aw_prev = 1'b0;
    logic [15:0] lfsr;

    tb_clkgen u_clkgen (.clk(clk), .rstn(rstn));

    l2_axi_top u_l2_axi_top (.*);

    // beat and AW rise counters sampled mid cycle
    always @(negedge clk) begin
        if (fill_valid) fill_beats++;
        if (awvalid && !aw_prev) aw_count++;
        aw_prev = awvalid;
    end

    task automatic after_edge();
        @(posedge clk);
        #1;
    endtask

    // galois form, taps x^16 x^14 x^13 x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_stall();   // 0..3 cycles with one lfsr step per bit
        int d;
        d = 0;
        repeat (2) begin
            lfsr = lfsr_next(lfsr);
            d = d * 2 + int'(lfsr[0]);
        end
        repeat (d) after_edge();
    endtask

    task automatic note_error();
        errors++;
        test_errs++;
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            note_error();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            note_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
            note_error();
        end
    endtask

    task automatic read_stim();
        int          fd;
        int          cnt;
        string       line;
        logic [7:0]  op;
        logic [31:0] a, w0, w1, w2, w3, r, eb;
        fd = $fopen("l2_axi_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file l2_axi_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_ops < MAX_OPS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            cnt = $sscanf(line, "%c %h %h %h %h %h %h %h", op, a, w0, w1, w2, w3, r, eb);
            if (cnt != 8) begin
                $display("malformed stimulus line: %s", line);
                errors++;
                continue;
            end
            op_code[n_ops]     = op;
            op_addr[n_ops]     = a;
            op_words[n_ops][0] = w0;
            op_words[n_ops][1] = w1;
            op_words[n_ops][2] = w2;
            op_words[n_ops][3] = w3;
            op_resp[n_ops]     = r[1:0];
            op_ebeat[n_ops]    = int'(eb);
            n_ops++;
        end
        $fclose(fd);
        if (n_ops == 0) begin
            $display("no operations found in the stimulus file");
            errors++;
        end
    endtask

    // AR then R beats checked against the file words
    task automatic read_slave(input int i);
        int n;
        n = 0;
        while (!arvalid) begin
            @(negedge clk);
            n++;
        end
        check_flag("arvalid_two_cycles", n == 3, 1'b1);   // start edge plus two
        after_edge();
        random_stall();
        arready = 1'b1;
        @(negedge clk);
        check_addr("araddr", araddr, op_addr[i]);
        after_edge();
        arready = 1'b0;
        for (int k = 0; k < NW; k++) begin
            random_stall();
            rvalid = 1'b1;
            rdata  = op_words[i][k];
            rresp  = (k == op_ebeat[i]) ? op_resp[i] : 2'b00;
            rlast  = (k == NW - 1);
            @(negedge clk);
            check_flag("fill_valid", fill_valid, 1'b1);
            check_word("fill_data", fill_data, op_words[i][k]);
            check_flag("fill_done", fill_done, k == NW - 1);
            if (k == NW - 1) check_flag("fill_err", fill_err, op_resp[i] != 2'b00);
            after_edge();
            rvalid = 1'b0;
            rlast  = 1'b0;
            rresp  = 2'b00;
        end
    endtask

    // AW, W beats and B with inverted words for a P line
    task automatic write_slave(input int i, input addr_t a, input logic inv, input resp_t resp);
        while (!awvalid) @(negedge clk);
        after_edge();
        random_stall();
        awready = 1'b1;
        @(negedge clk);
        check_addr("awaddr", awaddr, a);
        after_edge();
        awready = 1'b0;
        for (int k = 0; k < NW; k++) begin
            random_stall();
            wready = 1'b1;
            @(negedge clk);
            while (!wvalid) @(negedge clk);
            check_word("wdata", wdata, inv ? ~op_words[i][k] : op_words[i][k]);
            check_flag("wlast", wlast, k == NW - 1);
            after_edge();
            wready = 1'b0;
        end
        random_stall();
        bvalid = 1'b1;
        bresp  = resp;
        @(negedge clk);
        while (!bready) @(negedge clk);
        check_flag("evict_done", evict_done, 1'b1);
        check_flag("evict_err", evict_err, resp != 2'b00);
        after_edge();
        bvalid = 1'b0;
        bresp  = 2'b00;
    endtask

    // fills the victim fifo until wready drops
    task automatic load_words(input int i, input logic inv);
        for (int k = 0; k < NW; k++) begin
            after_edge();
            evict_wvalid = 1'b1;
            evict_wdata  = inv ? ~op_words[i][k] : op_words[i][k];
            @(negedge clk);
            check_flag("evict_wready", evict_wready, 1'b1);
        end
        after_edge();
        evict_wvalid = 1'b0;
        @(negedge clk);
        check_flag("evict_wready_full", evict_wready, 1'b0);
    endtask

    task automatic run_fill(input int i);
        int base;
        after_edge();
        fill_addr  = op_addr[i];
        fill_start = 1'b1;
        base       = fill_beats;
        fork
            read_slave(i);
            begin
                after_edge();
                fill_start = 1'b0;
                @(negedge clk);
                check_flag("fill_busy", fill_busy, 1'b1);
            end
        join
        repeat (3) after_edge();
        check_flag("fill_beat_count", (fill_beats - base) == NW, 1'b1);
        check_flag("fill_busy_clear", fill_busy, 1'b0);
    endtask

    task automatic run_evict(input int i, input resp_t resp);
        int base;
        load_words(i, 1'b0);
        after_edge();
        evict_addr  = op_addr[i];
        evict_start = 1'b1;
        base        = aw_count;
        fork
            write_slave(i, op_addr[i], 1'b0, resp);
            begin
                after_edge();
                evict_start = 1'b0;
                repeat (2) after_edge();
                evict_start = 1'b1;   // second start while the channel is busy
                @(negedge clk);
                check_flag("evict_busy", evict_busy, 1'b1);
                after_edge();
                evict_start = 1'b0;
            end
        join
        repeat (3) after_edge();
        check_flag("single_aw", (aw_count - base) == 1, 1'b1);
    endtask

    task automatic run_both(input int i);
        int base;
        load_words(i, 1'b1);
        after_edge();
        fill_addr   = op_addr[i];
        evict_addr  = op_addr[i] + 32'h1000;
        fill_start  = 1'b1;
        evict_start = 1'b1;
        base        = fill_beats;
        fork
            read_slave(i);
            write_slave(i, op_addr[i] + 32'h1000, 1'b1, 2'b00);
            begin
                after_edge();
                fill_start  = 1'b0;
                evict_start = 1'b0;
            end
        join
        repeat (3) after_edge();
        check_flag("fill_beat_count", (fill_beats - base) == NW, 1'b1);
    endtask

    initial begin
        fill_start   = 1'b0;
        fill_addr    = '0;
        evict_start  = 1'b0;
        evict_addr   = '0;
        evict_wvalid = 1'b0;
        evict_wdata  = '0;
        arready      = 1'b0;
        rdata        = '0;
        rresp        = 2'b00;
        rvalid       = 1'b0;
        rlast        = 1'b0;
        awready      = 1'b0;
        wready       = 1'b0;
        bresp        = 2'b00;
        bvalid       = 1'b0;
        lfsr         = 16'd36055;
        read_stim();
        limit_cycles = n_ops * 200;
        wait (rstn);
        @(negedge clk);
        check_flag("arvalid", arvalid, 1'b0);
        check_flag("awvalid", awvalid, 1'b0);
        check_flag("wvalid", wvalid, 1'b0);
        check_flag("rready", rready, 1'b0);
        check_flag("bready", bready, 1'b0);
        $display("test reset: %s", (errors == 0) ? "ok" : "failed");
        for (int i = 0; i < n_ops; i++) begin
            test_errs = 0;
            case (op_code[i])
                "F": run_fill(i);
                "E": run_evict(i, 2'b00);
                "X": run_evict(i, op_resp[i]);
                "P": run_both(i);
                default: begin
                    $display("unknown operation %c on stimulus entry %0d", op_code[i], i);
                    note_error();
                end
            endcase
            $display("test %0d op %c addr %h: %s", i, op_code[i], op_addr[i],
                     (test_errs == 0) ? "ok" : "failed");
            repeat (4) after_edge();
        end
        $display("%0d tests, %0d checks, %0d errors", n_ops, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog scaled by the number of operations
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout, tests still running after %0d cycles", limit_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== l2_axi_stim.txt ====
# op addr word0 word1 word2 word3 resp err_beat, all hex; F fill, E evict, X evict with bresp
# P fill at addr plus evict at addr+1000 with inverted words; resp on R beat err_beat for F and P
F 00001000 11111111 22222222 33333333 44444444 0 0
F 00002040 deadbeef cafef00d 0badc0de 12345678 0 0
E 00003000 a5a5a5a5 5a5a5a5a 01234567 89abcdef 0 0
E 00003040 00000001 00000002 00000004 00000008 0 0
P 00004000 13579bdf 2468ace0 fedcba98 76543210 0 0
F 00005000 aaaa0000 bbbb1111 cccc2222 dddd3333 2 2
F 00005040 0f0f0f0f f0f0f0f0 00ff00ff ff00ff00 3 0
X 00006000 10203040 50607080 90a0b0c0 d0e0f000 2 0
P 00007080 cafebabe feedface 8badf00d 1badb002 0 0
E 00008000 ffffffff 00000000 ffffffff 00000000 0 0
F 0000a0c0 00c0ffee 0defaced 0facade0 0dec0ded 2 3
P 0000b000 31415926 53589793 23846264 33832795 2 1
X 0000c040 27182818 28459045 23536028 74713527 2 0
E 0000d000 01010101 02020202 03030303 04040404 0 0
P 0000e000 89abcdef 01234567 76543210 fedcba98 0 0
F 0000f000 55555555 66666666 77777777 88888888 0 0

// ==== sim.f ====
+incdir+.
l2_axi_pkg.sv
l2_rd_if.sv
l2_wr_if.sv
l2_line_ctrl.sv
l2_wb_buffer.sv
l2_axi_interface.sv
l2_axi_top.sv
tb_clkgen.sv
tb_l2_axi.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_l2_axi \
    -Mdir obj_dir -o tb_l2_axi_sim
./obj_dir/tb_l2_axi_sim 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation finished without failures"
